// File: ccv_cfg_pkg.sv
/* Widths, register types and algorithm encodings of the coherency test controller
   Referenced by scoped name from the RTL and from the testbench */
package ccv_cfg_pkg;

  // ========================================================================
  // Register field types
  // ========================================================================

  // Byte address at cache-line granularity as held in the base registers
  typedef logic [51:0] addr_t;

  // Data pattern word that the execute engine writes and verify checks
  typedef logic [31:0] pattern_t;

  // Raw set offset in cache lines before it is scaled to bytes
  typedef logic [31:0] set_offset_t;

  // Eight-bit count registers for address increments, sets and loops
  typedef logic [7:0] count_reg_t;

  // Left shift that turns the raw set offset into a byte offset of whole lines
  localparam int unsigned set_offset_shift = 6;

  // ========================================================================
  // Algorithm select
  // ========================================================================

  // Encodings as they appear in the algorithm register
  // Zero selects no algorithm and stops a running test
  typedef enum logic [2:0] {
    alg_none = 3'd0,
    alg_1a   = 3'd1,
    alg_1b   = 3'd2,
    alg_2    = 3'd4
  } alg_e;

endpackage

// File: alg1a_state_pkg.sv
/* State encoding of the Algorithm 1a sequencer */
package alg1a_state_pkg;

  // ========================================================================
  // Sequencer states
  // ========================================================================

  // One pass of the algorithm goes init, execute, verify, check, set, loop
  // Disable_started drains a busy verify engine before the test ends
  typedef enum logic [3:0] {
    idle             = 4'd0,
    init             = 4'd1,
    execute_start    = 4'd2,
    execute_wait     = 4'd3,
    verify_start     = 4'd4,
    verify_wait      = 4'd5,
    check_if_error   = 4'd6,
    set_count_check  = 4'd7,
    loop_count_check = 4'd8,
    disable_started  = 4'd9,
    complete         = 4'd10
  } state_e;

endpackage

// File: alg1a_sequencer.sv
/* Algorithm 1a sequencer that runs the execute and self-checking verify engines per set
   All engine and set walker controls are single-cycle pulses decoded from the state */
module alg1a_sequencer
(
  input  logic              clk,
  input  logic              reset_n,
  input  logic              enable_in,
  input  logic              force_disable_afu,
  input  ccv_cfg_pkg::alg_e algorithm,
  input  logic              execute_busy_flag,
  input  logic              execute_slverr_received,
  input  logic              sc_verify_busy_flag,
  input  logic              sc_verify_error_found_flag,
  input  logic              sc_verify_poison_received,
  input  logic              sc_verify_slverr_received,
  input  logic              last_set,
  input  logic              loops_done,
  output logic              enable_execute_flag,
  output logic              enable_sc_verify_flag,
  output logic              init_loop,
  output logic              increment_set,
  output logic              set_next_set,
  output logic              increment_loop,
  output logic              set_to_busy,
  output logic              set_to_not_busy,
  output logic              busy_flag
);

  alg1a_state_pkg::state_e state;
  alg1a_state_pkg::state_e next_state;

  // High while the algorithm register still asks for Algorithm 1a
  logic alg_1a_selected;
  // Any condition that ends the test after a verify pass
  logic test_failed;

  assign alg_1a_selected = (algorithm == ccv_cfg_pkg::alg_1a);

  // A mismatch counts the same as a bus error or poisoned data
  assign test_failed = sc_verify_poison_received | sc_verify_slverr_received |
                       execute_slverr_received | sc_verify_error_found_flag;

  // ========================================================================
  // State and busy registers
  // ========================================================================

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      state <= alg1a_state_pkg::idle;
    // A forced disable still passes through complete so set_to_not_busy pulses
    else if (force_disable_afu)
      state <= alg1a_state_pkg::complete;
    else
      state <= next_state;
  end

  // Busy rises the cycle after set_to_busy and falls the cycle after set_to_not_busy
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      busy_flag <= 1'b0;
    else if (force_disable_afu)
      busy_flag <= 1'b0;
    else if (set_to_busy)
      busy_flag <= 1'b1;
    else if (set_to_not_busy)
      busy_flag <= 1'b0;
  end

  // ========================================================================
  // Next state and pulse decode
  // ========================================================================

  always_comb
  begin
    next_state            = state;
    enable_execute_flag   = 1'b0;
    enable_sc_verify_flag = 1'b0;
    init_loop             = 1'b0;
    increment_set         = 1'b0;
    set_next_set          = 1'b0;
    increment_loop        = 1'b0;
    set_to_busy           = 1'b0;
    set_to_not_busy       = 1'b0;

    case (state)
      alg1a_state_pkg::idle:
      begin
        // The start strobe is taken in the same cycle it is seen
        if (enable_in)
        begin
          set_to_busy = 1'b1;
          next_state  = alg1a_state_pkg::init;
        end
      end

      alg1a_state_pkg::init:
      begin
        // Reload address and pattern from the bases at the top of each loop
        init_loop  = 1'b1;
        next_state = alg1a_state_pkg::execute_start;
      end

      alg1a_state_pkg::execute_start:
      begin
        enable_execute_flag = 1'b1;
        next_state          = alg1a_state_pkg::execute_wait;
      end

      alg1a_state_pkg::execute_wait:
      begin
        // The engine raised busy the cycle after the pulse, so low here means done
        if (!execute_busy_flag)
          next_state = alg1a_state_pkg::verify_start;
      end

      alg1a_state_pkg::verify_start:
      begin
        enable_sc_verify_flag = 1'b1;
        next_state            = alg1a_state_pkg::verify_wait;
      end

      alg1a_state_pkg::verify_wait:
      begin
        if (!alg_1a_selected)
          next_state = alg1a_state_pkg::disable_started;
        else if (!sc_verify_busy_flag)
          next_state = alg1a_state_pkg::check_if_error;
      end

      alg1a_state_pkg::check_if_error:
      begin
        if (!alg_1a_selected)
          next_state = alg1a_state_pkg::disable_started;
        else if (test_failed)
          next_state = alg1a_state_pkg::complete;
        else
        begin
          // Clean set so step the walker to the following one
          increment_set = 1'b1;
          next_state    = alg1a_state_pkg::set_count_check;
        end
      end

      alg1a_state_pkg::set_count_check:
      begin
        if (!alg_1a_selected)
          next_state = alg1a_state_pkg::disable_started;
        else if (last_set)
        begin
          increment_loop = 1'b1;
          next_state     = alg1a_state_pkg::loop_count_check;
        end
        else
        begin
          set_next_set = 1'b1;
          next_state   = alg1a_state_pkg::execute_start;
        end
      end

      alg1a_state_pkg::loop_count_check:
      begin
        // loops_done never rises for a loop count of zero, which loops forever
        if (algorithm == ccv_cfg_pkg::alg_none)
          next_state = alg1a_state_pkg::disable_started;
        else if (loops_done)
          next_state = alg1a_state_pkg::complete;
        else
          next_state = alg1a_state_pkg::init;
      end

      alg1a_state_pkg::disable_started:
      begin
        // Graceful stop waits for verify unless a mismatch is already known
        if (sc_verify_error_found_flag || !sc_verify_busy_flag)
          next_state = alg1a_state_pkg::complete;
      end

      alg1a_state_pkg::complete:
      begin
        set_to_not_busy = 1'b1;
        next_state      = alg1a_state_pkg::idle;
      end

      default:
      begin
        next_state = alg1a_state_pkg::idle;
      end
    endcase
  end

endmodule

// File: alg1a_set_walker.sv
/* Set and loop counters with the current and next address and pattern of Algorithm 1a
   Driven by the sequencer pulses, each register updates on the edge after its pulse */
module alg1a_set_walker
#(
  parameter int unsigned set_count_width  = 5,
  parameter int unsigned loop_count_width = 10
)
(
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          clear_loops,
  input  logic                          init_loop,
  input  logic                          increment_set,
  input  logic                          set_next_set,
  input  logic                          increment_loop,
  input  ccv_cfg_pkg::addr_t            base_start_address,
  input  ccv_cfg_pkg::pattern_t         base_pattern,
  input  ccv_cfg_pkg::set_offset_t      address_set_offset,
  input  ccv_cfg_pkg::count_reg_t       number_of_address_increments,
  input  ccv_cfg_pkg::count_reg_t       number_of_sets,
  input  ccv_cfg_pkg::count_reg_t       number_of_loops,
  input  logic                          pattern_parameter,
  output ccv_cfg_pkg::addr_t            current_x,
  output ccv_cfg_pkg::pattern_t         current_p,
  output logic [set_count_width-1:0]    set_count,
  output logic [loop_count_width-1:0]   loop_count,
  output logic                          last_set,
  output logic                          loops_done
);

  // Address and pattern of the set that follows the current one
  ccv_cfg_pkg::addr_t    next_x;
  ccv_cfg_pkg::pattern_t next_p;

  // Set offset scaled to bytes and the per-set pattern step
  ccv_cfg_pkg::addr_t    set_offset_bytes;
  ccv_cfg_pkg::pattern_t pattern_step;

  assign set_offset_bytes = {20'd0, address_set_offset} << ccv_cfg_pkg::set_offset_shift;

  // Each set moves the pattern past every word the previous set wrote
  assign pattern_step = 32'd1 + {24'd0, number_of_address_increments};

  // ========================================================================
  // Set and loop counters
  // ========================================================================

  // Only the low nibble of the sets register carries the set count
  assign last_set = (set_count >= set_count_width'(number_of_sets[3:0]));

  // A loop count of zero means run until disabled
  assign loops_done = (number_of_loops != 8'd0) &&
                      (loop_count >= loop_count_width'(number_of_loops));

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      set_count <= '0;
    else if (init_loop)
      set_count <= '0;
    else if (increment_set)
      set_count <= set_count + set_count_width'(1);
  end

  // Cleared once per test, not per loop
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      loop_count <= '0;
    else if (clear_loops)
      loop_count <= '0;
    else if (increment_loop)
      loop_count <= loop_count + loop_count_width'(1);
  end

  // ========================================================================
  // Address and pattern registers
  // ========================================================================

  // The next values run one set ahead and are copied over on set_next_set
  always_ff @(posedge clk)
  begin
    if (init_loop)
    begin
      next_x <= base_start_address;
      next_p <= base_pattern;
    end
    else if (increment_set)
    begin
      next_x <= next_x + set_offset_bytes;
      // Without pattern_parameter every set writes the same base pattern
      if (pattern_parameter)
        next_p <= next_p + pattern_step;
      else
        next_p <= base_pattern;
    end
  end

  // Values handed to the engines for the set being worked on
  always_ff @(posedge clk)
  begin
    if (init_loop)
    begin
      current_x <= base_start_address;
      current_p <= base_pattern;
    end
    else if (set_next_set)
    begin
      current_x <= next_x;
      current_p <= next_p;
    end
  end

endmodule

// File: alg1a_top.sv
/* Top level of the Algorithm 1a test controller joining sequencer and set walker
   Sets the set and loop counter widths for the whole tree */
module alg1a_top
#(
  parameter int unsigned set_count_width  = 5,
  parameter int unsigned loop_count_width = 10
)
(
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          enable_in,
  input  logic                          force_disable_afu,
  input  ccv_cfg_pkg::alg_e             algorithm,
  input  logic                          execute_busy_flag,
  input  logic                          execute_slverr_received,
  input  logic                          sc_verify_busy_flag,
  input  logic                          sc_verify_error_found_flag,
  input  logic                          sc_verify_poison_received,
  input  logic                          sc_verify_slverr_received,
  input  ccv_cfg_pkg::addr_t            base_start_address,
  input  ccv_cfg_pkg::pattern_t         base_pattern,
  input  ccv_cfg_pkg::set_offset_t      address_set_offset,
  input  ccv_cfg_pkg::count_reg_t       number_of_address_increments,
  input  ccv_cfg_pkg::count_reg_t       number_of_sets,
  input  ccv_cfg_pkg::count_reg_t       number_of_loops,
  input  logic                          pattern_parameter,
  output logic                          enable_execute_flag,
  output logic                          enable_sc_verify_flag,
  output ccv_cfg_pkg::addr_t            current_x,
  output ccv_cfg_pkg::pattern_t         current_p,
  output logic [set_count_width-1:0]    set_count,
  output logic [loop_count_width-1:0]   loop_count,
  output logic                          set_to_busy,
  output logic                          set_to_not_busy,
  output logic                          busy_flag
);

  // Step pulses from the sequencer
  logic init_loop;
  logic increment_set;
  logic set_next_set;
  logic increment_loop;
  // Levels returned by the set walker
  logic last_set;
  logic loops_done;

  // ========================================================================
  // Sequencer
  // ========================================================================

  alg1a_sequencer i_alg1a_sequencer (
    .clk                        (clk),
    .reset_n                    (reset_n),
    .enable_in                  (enable_in),
    .force_disable_afu          (force_disable_afu),
    .algorithm                  (algorithm),
    .execute_busy_flag          (execute_busy_flag),
    .execute_slverr_received    (execute_slverr_received),
    .sc_verify_busy_flag        (sc_verify_busy_flag),
    .sc_verify_error_found_flag (sc_verify_error_found_flag),
    .sc_verify_poison_received  (sc_verify_poison_received),
    .sc_verify_slverr_received  (sc_verify_slverr_received),
    .last_set                   (last_set),
    .loops_done                 (loops_done),
    .enable_execute_flag        (enable_execute_flag),
    .enable_sc_verify_flag      (enable_sc_verify_flag),
    .init_loop                  (init_loop),
    .increment_set              (increment_set),
    .set_next_set               (set_next_set),
    .increment_loop             (increment_loop),
    .set_to_busy                (set_to_busy),
    .set_to_not_busy            (set_to_not_busy),
    .busy_flag                  (busy_flag)
  );

  // ========================================================================
  // Set walker
  // ========================================================================

  // The loop counter clears on the same pulse that starts the test
  alg1a_set_walker #(
    .set_count_width  (set_count_width),
    .loop_count_width (loop_count_width)
  ) i_alg1a_set_walker (
    .clk                          (clk),
    .reset_n                      (reset_n),
    .clear_loops                  (set_to_busy),
    .init_loop                    (init_loop),
    .increment_set                (increment_set),
    .set_next_set                 (set_next_set),
    .increment_loop               (increment_loop),
    .base_start_address           (base_start_address),
    .base_pattern                 (base_pattern),
    .address_set_offset           (address_set_offset),
    .number_of_address_increments (number_of_address_increments),
    .number_of_sets               (number_of_sets),
    .number_of_loops              (number_of_loops),
    .pattern_parameter            (pattern_parameter),
    .current_x                    (current_x),
    .current_p                    (current_p),
    .set_count                    (set_count),
    .loop_count                   (loop_count),
    .last_set                     (last_set),
    .loops_done                   (loops_done)
  );

endmodule

// File: tb_alg1a_tasks.svh
/* Directed tests of the Algorithm 1a controller with the expected address and pattern model
   Included inside the testbench top module */

  // ========================================================================
  // Checks and reference model
  // ========================================================================

  function automatic void compare_value(input string name, input logic [63:0] got,
                                        input logic [63:0] expected);
    assert (got === expected)
    else
    begin
      $display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, got, expected);
      error_count++;
    end
  endfunction

  // A sets register whose low nibble is zero still runs one set
  function automatic int sets_per_loop();
    return (number_of_sets[3:0] == 4'd0) ? 1 : int'(number_of_sets[3:0]);
  endfunction

  // Set k sits k scaled offsets above the base address
  function automatic ccv_cfg_pkg::addr_t expected_address(input int k);
    logic [63:0] step;
    step = {32'd0, address_set_offset} << 6;
    return ccv_cfg_pkg::addr_t'({12'd0, base_start_address} + 64'(k) * step);
  endfunction

  // Each set moves the pattern by one more than the increments register
  function automatic ccv_cfg_pkg::pattern_t expected_pattern(input int k);
    if (!pattern_parameter)
      return base_pattern;
    return base_pattern + 32'(k) * (32'd1 + {24'd0, number_of_address_increments});
  endfunction

  // Index counts executes since the start, so the set is the index within its loop
  function automatic void check_set_values(input int index);
    int k;
    k = index % sets_per_loop();
    compare_value("set_count", set_count, k);
    compare_value("current_x", current_x, expected_address(k));
    compare_value("current_p", current_p, expected_pattern(k));
  endfunction

  // ========================================================================
  // Stimulus and wait helpers
  // ========================================================================

  task automatic wait_for_engines_idle();
    int cycles;
    for (cycles = 0; cycles < 100 && (execute_busy_flag || sc_verify_busy_flag); cycles++)
      @(posedge clk);
    if (execute_busy_flag || sc_verify_busy_flag)
      report_timeout("engine idle");
  endtask

  task automatic start_test(input int sets, input int loops, input logic pattern);
    wait_for_engines_idle();
    @(negedge clk);
    number_of_sets    = 8'(sets);
    number_of_loops   = 8'(loops);
    pattern_parameter = pattern;
    exec_count        = 0;
    verify_count      = 0;
    enable_in         = 1'b1;
    // The strobe is taken in idle, so set_to_busy is high in the cycle it is driven
    @(posedge clk);
    compare_value("set_to_busy", set_to_busy, 1'b1);
    @(negedge clk);
    enable_in = 1'b0;
    compare_value("busy_flag", busy_flag, 1'b1);
  endtask

  // Samples on the rising edge, where the values are those held through the cycle
  task automatic wait_for_end(input logic check_busy);
    int   cycles;
    logic seen;
    seen = 1'b0;
    for (cycles = 0; cycles < 2000 && !seen; cycles++)
    begin
      @(posedge clk);
      seen = set_to_not_busy;
      if (check_busy)
        compare_value("busy_flag", busy_flag, 1'b1);
    end
    if (!seen)
      report_timeout("set_to_not_busy");
    @(negedge clk);
    compare_value("busy_flag", busy_flag, 1'b0);
  endtask

  task automatic wait_for_pulses(input logic verify, input int count);
    int   cycles;
    logic reached;
    reached = 1'b0;
    for (cycles = 0; cycles < 2000 && !reached; cycles++)
    begin
      @(posedge clk);
      reached = verify ? (verify_count >= count) : (exec_count >= count);
    end
    if (!reached)
      report_timeout(verify ? "verify pulse count" : "execute pulse count");
  endtask

  task automatic clear_faults();
    @(negedge clk);
    fail_kind                  = fault_none;
    fail_set                   = -1;
    execute_slverr_received    = 1'b0;
    sc_verify_error_found_flag = 1'b0;
    sc_verify_poison_received  = 1'b0;
  endtask

  task automatic finish_test(input string name, input int errors_before);
    test_count++;
    $display("Test %s finished with %0d failed checks", name, error_count - errors_before);
  endtask

  // ========================================================================
  // Directed tests
  // ========================================================================

  task automatic test_reset_and_busy();
    int errors_before;
    errors_before = error_count;
    compare_value("busy_flag", busy_flag, 1'b0);
    compare_value("enable_execute_flag", enable_execute_flag, 1'b0);
    compare_value("enable_sc_verify_flag", enable_sc_verify_flag, 1'b0);
    start_test(1, 1, 1'b0);
    wait_for_end(1'b1);
    finish_test("reset_and_busy", errors_before);
  endtask

  // Three sets over two loops, with and without pattern stepping
  task automatic test_address_walk();
    int errors_before;
    errors_before = error_count;
    start_test(3, 2, 1'b1);
    wait_for_end(1'b1);
    compare_value("execute pulse count", exec_count, 6);
    compare_value("verify pulse count", verify_count, 6);
    start_test(3, 2, 1'b0);
    wait_for_end(1'b1);
    compare_value("execute pulse count", exec_count, 6);
    compare_value("verify pulse count", verify_count, 6);
    finish_test("address_walk", errors_before);
  endtask

  // The failing set is the last one that gets an execute
  task automatic run_with_fault(input int kind, input int set_index);
    @(negedge clk);
    fail_kind = kind;
    fail_set  = set_index;
    start_test(3, 2, 1'b1);
    wait_for_end(1'b1);
    compare_value("execute pulse count", exec_count, set_index + 1);
    compare_value("verify pulse count", verify_count, set_index + 1);
    clear_faults();
  endtask

  task automatic test_verify_mismatch();
    int errors_before;
    errors_before = error_count;
    run_with_fault(fault_mismatch, 1);
    finish_test("verify_mismatch", errors_before);
  endtask

  task automatic test_engine_faults();
    int errors_before;
    errors_before = error_count;
    run_with_fault(fault_exec_slverr, 2);
    run_with_fault(fault_poison, 0);
    finish_test("engine_faults", errors_before);
  endtask

  // Zero loops runs until the forced disable
  task automatic test_endless_loops();
    int errors_before;
    int pulses;
    errors_before = error_count;
    pulses        = 0;
    start_test(2, 0, 1'b1);
    wait_for_pulses(1'b0, 4 * 2 + 1);
    // The ninth execute opens the fifth loop, after four finished loops
    compare_value("loop_count", loop_count, 4);
    @(negedge clk);
    force_disable_afu = 1'b1;
    @(negedge clk);
    force_disable_afu = 1'b0;
    compare_value("busy_flag", busy_flag, 1'b0);
    repeat (4)
    begin
      @(posedge clk);
      if (set_to_not_busy)
        pulses++;
    end
    compare_value("set_to_not_busy pulse count", pulses, 1);
    finish_test("endless_loops", errors_before);
  endtask

  // Switching away from 1a mid-verify drains verify before busy drops
  task automatic test_algorithm_change();
    int errors_before;
    errors_before = error_count;
    verify_extra  = 20;
    start_test(3, 1, 1'b1);
    wait_for_pulses(1'b1, 1);
    compare_value("sc_verify_busy_flag", sc_verify_busy_flag, 1'b1);
    @(negedge clk);
    algorithm = ccv_cfg_pkg::alg_1b;
    wait_for_end(1'b1);
    compare_value("sc_verify_busy_flag", sc_verify_busy_flag, 1'b0);
    compare_value("execute pulse count", exec_count, 1);
    algorithm    = ccv_cfg_pkg::alg_1a;
    verify_extra = 0;
    finish_test("algorithm_change", errors_before);
  endtask

// File: tb_alg1a_top.sv
/* Testbench for the Algorithm 1a controller with execute and self-checking verify models
   Compile with alg1a_top.f and simulate tb_alg1a_top as the top module */
module tb_alg1a_top;

  timeunit 1ns;
  timeprecision 100ps;

  // Fault kinds that the engine models can inject
  localparam int fault_none        = 0;
  localparam int fault_mismatch    = 1;
  localparam int fault_poison      = 2;
  localparam int fault_exec_slverr = 3;

  logic                     clk;
  logic                     reset_n;
  logic                     enable_in;
  logic                     force_disable_afu;
  ccv_cfg_pkg::alg_e        algorithm;
  logic                     execute_busy_flag;
  logic                     execute_slverr_received;
  logic                     sc_verify_busy_flag;
  logic                     sc_verify_error_found_flag;
  logic                     sc_verify_poison_received;
  logic                     sc_verify_slverr_received;
  ccv_cfg_pkg::addr_t       base_start_address;
  ccv_cfg_pkg::pattern_t    base_pattern;
  ccv_cfg_pkg::set_offset_t address_set_offset;
  ccv_cfg_pkg::count_reg_t  number_of_address_increments;
  ccv_cfg_pkg::count_reg_t  number_of_sets;
  ccv_cfg_pkg::count_reg_t  number_of_loops;
  logic                     pattern_parameter;
  logic                     enable_execute_flag;
  logic                     enable_sc_verify_flag;
  ccv_cfg_pkg::addr_t       current_x;
  ccv_cfg_pkg::pattern_t    current_p;
  logic [4:0]               set_count;
  logic [9:0]               loop_count;
  logic                     set_to_busy;
  logic                     set_to_not_busy;
  logic                     busy_flag;

  // Pulses seen since the current test was started
  int exec_count;
  int verify_count;
  // Remaining busy cycles of each engine model
  int exec_left;
  int verify_left;
  // Added verify busy cycles, used to hold verify busy across an algorithm change
  int verify_extra;
  // Engine fault to inject and the set index where it hits
  int fail_kind;
  int fail_set;
  int error_count;
  int test_count;

  alg1a_top #(
    .set_count_width  (5),
    .loop_count_width (10)
  ) i_alg1a_top (.*);

  // Ends the run when a wait loop runs out of cycles
  task automatic report_timeout(input string what);
    $display("Timeout: %s did not happen in time", what);
    $display("CHECKS FAILED");
    $finish;
  endtask

  `include "tb_alg1a_tasks.svh"

  always #4 clk = ~clk;

  // ========================================================================
  // Engine models and address monitor
  // ========================================================================

  // Runs on the falling edge, where DUT outputs are settled and engine levels are driven
  always @(negedge clk)
  begin
    if (enable_execute_flag)
    begin
      check_set_values(exec_count);
      // Every earlier execute must already have had its verify
      compare_value("verify pulse count", verify_count, exec_count);
      if (fail_kind == fault_exec_slverr && fail_set == exec_count)
        execute_slverr_received = 1'b1;
      exec_count++;
      execute_busy_flag = 1'b1;
      // One extra count so busy is still high at the edge after the pulse
      exec_left = 2 + $urandom % 8;
    end
    else if (exec_left > 0)
    begin
      exec_left--;
      if (exec_left == 0)
        execute_busy_flag = 1'b0;
    end

    if (enable_sc_verify_flag)
    begin
      if (fail_kind == fault_mismatch && fail_set == verify_count)
        sc_verify_error_found_flag = 1'b1;
      if (fail_kind == fault_poison && fail_set == verify_count)
        sc_verify_poison_received = 1'b1;
      verify_count++;
      sc_verify_busy_flag = 1'b1;
      verify_left = 2 + $urandom % 8 + verify_extra;
    end
    else if (verify_left > 0)
    begin
      verify_left--;
      if (verify_left == 0)
        sc_verify_busy_flag = 1'b0;
    end
  end

  // ========================================================================
  // Test sequence
  // ========================================================================

  initial
  begin
    clk                          = 1'b0;
    reset_n                      = 1'b0;
    enable_in                    = 1'b0;
    force_disable_afu            = 1'b0;
    algorithm                    = ccv_cfg_pkg::alg_1a;
    execute_busy_flag            = 1'b0;
    execute_slverr_received      = 1'b0;
    sc_verify_busy_flag          = 1'b0;
    sc_verify_error_found_flag   = 1'b0;
    sc_verify_poison_received    = 1'b0;
    sc_verify_slverr_received    = 1'b0;
    base_start_address           = 52'h0_1234_5678_9a40;
    base_pattern                 = 32'hcafe_0000;
    address_set_offset           = 32'h0000_0010;
    number_of_address_increments = 8'd4;
    number_of_sets               = 8'd1;
    number_of_loops              = 8'd1;
    pattern_parameter            = 1'b0;
    exec_count                   = 0;
    verify_count                 = 0;
    exec_left                    = 0;
    verify_left                  = 0;
    verify_extra                 = 0;
    fail_kind                    = fault_none;
    fail_set                     = -1;
    error_count                  = 0;
    test_count                   = 0;
    void'($urandom(32'h00f1e055));

    repeat (4) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    test_reset_and_busy();
    test_address_walk();
    test_verify_mismatch();
    test_engine_faults();
    test_endless_loops();
    test_algorithm_change();

    $display("%0d tests run, %0d checks failed", test_count, error_count);
    if (error_count == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: alg1a_top.f
+incdir+.
ccv_cfg_pkg.sv
alg1a_state_pkg.sv
alg1a_sequencer.sv
alg1a_set_walker.sv
alg1a_top.sv
tb_alg1a_top.sv
